//--- Makefile
VERILATOR ?= verilator
TOP       ?= barrel_core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= all tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(abspath $(BIN)) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/barrel_core.sv
// Barrel threaded core top level
`timescale 1ns/1ns

module barrel_core (
  input  logic                    CLK,
  input  logic                    reset,
  output logic                    ics,
  output barrel_core_pkg::iaddr_t iaddr,
  input  barrel_core_pkg::word_t  idata,
  output logic                    dcs,
  output logic                    dwr,
  output barrel_core_pkg::word_t  daddr,
  output barrel_core_pkg::word_t  dout,
  input  barrel_core_pkg::word_t  din,
  output logic                    done
);

  barrel_core_pkg::slice_t     dec_slice;
  logic                        au_op_vld;
  barrel_core_pkg::au_opcode_t au_opcode;
  barrel_core_pkg::reg_sel_t   au_rd;
  barrel_core_pkg::reg_sel_t   au_ra_sel;
  barrel_core_pkg::reg_sel_t   au_rb_sel;
  logic [7:0]                  au_imm;
  logic                        ls_op_vld;
  barrel_core_pkg::ls_opcode_t ls_opcode;
  barrel_core_pkg::reg_sel_t   ls_data_sel;
  barrel_core_pkg::reg_sel_t   ls_ptr_sel;
  logic [7:0]                  ls_offset;

  barrel_core_pkg::word_t      au_ra;
  barrel_core_pkg::word_t      au_rb;
  barrel_core_pkg::word_t      ls_ptr;
  barrel_core_pkg::word_t      ls_store;

  logic                        au_wr_vld;
  barrel_core_pkg::slice_t     au_wr_slice;
  barrel_core_pkg::reg_sel_t   au_wr_sel;
  barrel_core_pkg::word_t      au_wr_data;

  logic                        ld_vld;
  barrel_core_pkg::slice_t     ld_slice;
  barrel_core_pkg::reg_sel_t   ld_sel;
  barrel_core_pkg::word_t      ld_data;

  core_fetch core_fetch_i (
    .CLK(CLK),
    .reset(reset),
    .ics(ics),
    .iaddr(iaddr),
    .idata(idata),
    .dec_slice(dec_slice),
    .au_op_vld(au_op_vld),
    .au_opcode(au_opcode),
    .au_rd(au_rd),
    .au_ra_sel(au_ra_sel),
    .au_rb_sel(au_rb_sel),
    .au_imm(au_imm),
    .ls_op_vld(ls_op_vld),
    .ls_opcode(ls_opcode),
    .ls_data_sel(ls_data_sel),
    .ls_ptr_sel(ls_ptr_sel),
    .ls_offset(ls_offset),
    .done(done)
  );

  core_au core_au_i (
    .CLK(CLK),
    .reset(reset),
    .dec_slice(dec_slice),
    .au_op_vld(au_op_vld),
    .au_opcode(au_opcode),
    .au_rd(au_rd),
    .au_imm(au_imm),
    .au_ra(au_ra),
    .au_rb(au_rb),
    .au_wr_vld(au_wr_vld),
    .au_wr_slice(au_wr_slice),
    .au_wr_sel(au_wr_sel),
    .au_wr_data(au_wr_data)
  );

  core_ls core_ls_i (
    .CLK(CLK),
    .reset(reset),
    .dec_slice(dec_slice),
    .ls_op_vld(ls_op_vld),
    .ls_opcode(ls_opcode),
    .ls_data_sel(ls_data_sel),
    .ls_offset(ls_offset),
    .ls_ptr(ls_ptr),
    .ls_store(ls_store),
    .dcs(dcs),
    .dwr(dwr),
    .daddr(daddr),
    .dout(dout),
    .din(din),
    .ld_vld(ld_vld),
    .ld_slice(ld_slice),
    .ld_sel(ld_sel),
    .ld_data(ld_data)
  );

  core_regfile core_regfile_i (
    .CLK(CLK),
    .reset(reset),
    .dec_slice(dec_slice),
    .au_ra_sel(au_ra_sel),
    .au_ra(au_ra),
    .au_rb_sel(au_rb_sel),
    .au_rb(au_rb),
    .ls_ptr_sel(ls_ptr_sel),
    .ls_ptr(ls_ptr),
    .ls_data_sel(ls_data_sel),
    .ls_store(ls_store),
    .au_wr_vld(au_wr_vld),
    .au_wr_slice(au_wr_slice),
    .au_wr_sel(au_wr_sel),
    .au_wr_data(au_wr_data),
    .ld_vld(ld_vld),
    .ld_slice(ld_slice),
    .ld_sel(ld_sel),
    .ld_data(ld_data)
  );

endmodule

//--- rtl/barrel_core_defines.svh
// Barrel core sizing macros
`ifndef BARREL_CORE_DEFINES_SVH
`define BARREL_CORE_DEFINES_SVH

// Hardware threads that issue in fixed rotation
`define BC_SLICES 4

// Registers held for each slice
`define BC_REGS 8

// Program counter bits per slice
`define BC_PC_W 6

// Instruction address with the slice number above the program counter
`define BC_IADDR_W 8

`endif

//--- rtl/barrel_core_pkg.sv
// Barrel core shared types
package barrel_core_pkg;

`include "barrel_core_defines.svh"

  typedef logic [31:0] word_t;
  typedef logic [$clog2(`BC_SLICES)-1:0] slice_t;
  typedef logic [$clog2(`BC_REGS)-1:0] reg_sel_t;
  typedef logic [`BC_IADDR_W-1:0] iaddr_t;

  // Upper half of the instruction word
  typedef enum logic [3:0] {
    au_nop  = 4'd0,
    au_add  = 4'd1,
    au_sub  = 4'd2,
    au_and  = 4'd3,
    au_or   = 4'd4,
    au_xor  = 4'd5,
    au_shl  = 4'd6,
    au_ldi  = 4'd7,
    au_halt = 4'd8
  } au_opcode_t;

  // Lower half of the instruction word
  typedef enum logic [1:0] {
    ls_nop   = 2'd0,
    ls_load  = 2'd1,
    ls_store = 2'd2
  } ls_opcode_t;

  typedef enum logic [1:0] {
    f_reset = 2'd0,
    f_run   = 2'd1,
    f_done  = 2'd2
  } fetch_state_t;

endpackage

//--- rtl/core_au.sv
// Arithmetic unit
`timescale 1ns/1ns

module core_au (
  input  logic                        CLK,
  input  logic                        reset,
  input  barrel_core_pkg::slice_t     dec_slice,
  input  logic                        au_op_vld,
  input  barrel_core_pkg::au_opcode_t au_opcode,
  input  barrel_core_pkg::reg_sel_t   au_rd,
  input  logic [7:0]                  au_imm,
  input  barrel_core_pkg::word_t      au_ra,
  input  barrel_core_pkg::word_t      au_rb,
  output logic                        au_wr_vld,
  output barrel_core_pkg::slice_t     au_wr_slice,
  output barrel_core_pkg::reg_sel_t   au_wr_sel,
  output barrel_core_pkg::word_t      au_wr_data
);

  barrel_core_pkg::word_t result;
  logic                   writes_reg;

  always_comb begin
    writes_reg = 1'b1;
    case (au_opcode)
      barrel_core_pkg::au_add: result = au_ra + au_rb;
      barrel_core_pkg::au_sub: result = au_ra - au_rb;
      barrel_core_pkg::au_and: result = au_ra & au_rb;
      barrel_core_pkg::au_or:  result = au_ra | au_rb;
      barrel_core_pkg::au_xor: result = au_ra ^ au_rb;
      barrel_core_pkg::au_shl: result = au_ra << au_rb[4:0];
      barrel_core_pkg::au_ldi: result = {24'd0, au_imm};
      default: begin
        // Nop, halt and unused codes leave the register file alone
        result     = '0;
        writes_reg = 1'b0;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      au_wr_vld <= 1'b0;
    end else begin
      au_wr_vld <= au_op_vld && writes_reg;
    end
  end

  always_ff @(posedge CLK) begin
    au_wr_slice <= dec_slice;
    au_wr_sel   <= au_rd;
    au_wr_data  <= result;
  end

endmodule

//--- rtl/core_fetch.sv
// Fetch and decode unit
`timescale 1ns/1ns
`include "barrel_core_defines.svh"

module core_fetch (
  input  logic                        CLK,
  input  logic                        reset,
  output logic                        ics,
  output barrel_core_pkg::iaddr_t     iaddr,
  input  barrel_core_pkg::word_t      idata,
  output barrel_core_pkg::slice_t     dec_slice,
  output logic                        au_op_vld,
  output barrel_core_pkg::au_opcode_t au_opcode,
  output barrel_core_pkg::reg_sel_t   au_rd,
  output barrel_core_pkg::reg_sel_t   au_ra_sel,
  output barrel_core_pkg::reg_sel_t   au_rb_sel,
  output logic [7:0]                  au_imm,
  output logic                        ls_op_vld,
  output barrel_core_pkg::ls_opcode_t ls_opcode,
  output barrel_core_pkg::reg_sel_t   ls_data_sel,
  output barrel_core_pkg::reg_sel_t   ls_ptr_sel,
  output logic [7:0]                  ls_offset,
  output logic                        done
);

  barrel_core_pkg::fetch_state_t state;
  barrel_core_pkg::slice_t       slice_cnt;
  logic [`BC_PC_W-1:0]           pc [`BC_SLICES];
  logic [`BC_SLICES-1:0]         halted;
  logic                          dec_vld;
  logic [1:0]                    drain_cnt;
  logic                          all_halted;

  assign all_halted = &halted;

  // A halted slice keeps its turn in the rotation but issues nothing
  assign ics   = (state == barrel_core_pkg::f_run) && !halted[slice_cnt];
  assign iaddr = {slice_cnt, pc[slice_cnt]};
  assign done  = (state == barrel_core_pkg::f_done);

  always_ff @(posedge CLK) begin
    if (reset) begin
      state     <= barrel_core_pkg::f_reset;
      slice_cnt <= '0;
      halted    <= '0;
      dec_vld   <= 1'b0;
      dec_slice <= '0;
      drain_cnt <= '0;
      for (int i = 0; i < `BC_SLICES; i++) begin
        pc[i] <= '0;
      end
    end else begin
      dec_vld   <= ics;
      dec_slice <= slice_cnt;

      if (ics) begin
        pc[slice_cnt] <= pc[slice_cnt] + 1'b1;
      end

      if (dec_vld && (au_opcode == barrel_core_pkg::au_halt)) begin
        halted[dec_slice] <= 1'b1;
      end

      case (state)
        barrel_core_pkg::f_reset: begin
          state <= barrel_core_pkg::f_run;
        end
        barrel_core_pkg::f_run: begin
          slice_cnt <= slice_cnt + 1'b1;
          // Let the last loads and register writes drain before signalling done
          if (all_halted) begin
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == 2'd1) begin
              state <= barrel_core_pkg::f_done;
            end
          end
        end
        default: begin
          state <= barrel_core_pkg::f_done;
        end
      endcase
    end
  end

  // The instruction word arrives one cycle after ics and is decoded in place
  assign au_opcode   = barrel_core_pkg::au_opcode_t'(idata[31:28]);
  assign au_rd       = idata[27:25];
  assign au_ra_sel   = idata[24:22];
  assign au_rb_sel   = idata[21:19];
  assign au_imm      = idata[24:17];
  assign ls_opcode   = barrel_core_pkg::ls_opcode_t'(idata[15:14]);
  assign ls_data_sel = idata[13:11];
  assign ls_ptr_sel  = idata[10:8];
  assign ls_offset   = idata[7:0];

  assign au_op_vld = dec_vld && (au_opcode != barrel_core_pkg::au_nop);
  assign ls_op_vld = dec_vld && (ls_opcode != barrel_core_pkg::ls_nop);

endmodule

//--- rtl/core_ls.sv
// Load and store unit
`timescale 1ns/1ns

module core_ls (
  input  logic                        CLK,
  input  logic                        reset,
  input  barrel_core_pkg::slice_t     dec_slice,
  input  logic                        ls_op_vld,
  input  barrel_core_pkg::ls_opcode_t ls_opcode,
  input  barrel_core_pkg::reg_sel_t   ls_data_sel,
  input  logic [7:0]                  ls_offset,
  input  barrel_core_pkg::word_t      ls_ptr,
  input  barrel_core_pkg::word_t      ls_store,
  output logic                        dcs,
  output logic                        dwr,
  output barrel_core_pkg::word_t      daddr,
  output barrel_core_pkg::word_t      dout,
  input  barrel_core_pkg::word_t      din,
  output logic                        ld_vld,
  output barrel_core_pkg::slice_t     ld_slice,
  output barrel_core_pkg::reg_sel_t   ld_sel,
  output barrel_core_pkg::word_t      ld_data
);

  logic is_load;
  logic is_store;

  assign is_load  = ls_op_vld && (ls_opcode == barrel_core_pkg::ls_load);
  assign is_store = ls_op_vld && (ls_opcode == barrel_core_pkg::ls_store);

  // Offset counts words, so it is scaled by four
  assign daddr = ls_ptr + {22'd0, ls_offset, 2'b00};
  assign dout  = ls_store;
  assign dcs   = is_load || is_store;
  assign dwr   = is_store;

  always_ff @(posedge CLK) begin
    if (reset) begin
      ld_vld <= 1'b0;
    end else begin
      ld_vld <= is_load;
    end
  end

  // Target of the outstanding load is kept until din returns next cycle
  always_ff @(posedge CLK) begin
    ld_slice <= dec_slice;
    ld_sel   <= ls_data_sel;
  end

  assign ld_data = din;

endmodule

//--- rtl/core_regfile.sv
// Shared register file
`timescale 1ns/1ns
`include "barrel_core_defines.svh"

module core_regfile (
  input  logic                      CLK,
  input  logic                      reset,
  input  barrel_core_pkg::slice_t   dec_slice,
  input  barrel_core_pkg::reg_sel_t au_ra_sel,
  output barrel_core_pkg::word_t    au_ra,
  input  barrel_core_pkg::reg_sel_t au_rb_sel,
  output barrel_core_pkg::word_t    au_rb,
  input  barrel_core_pkg::reg_sel_t ls_ptr_sel,
  output barrel_core_pkg::word_t    ls_ptr,
  input  barrel_core_pkg::reg_sel_t ls_data_sel,
  output barrel_core_pkg::word_t    ls_store,
  input  logic                      au_wr_vld,
  input  barrel_core_pkg::slice_t   au_wr_slice,
  input  barrel_core_pkg::reg_sel_t au_wr_sel,
  input  barrel_core_pkg::word_t    au_wr_data,
  input  logic                      ld_vld,
  input  barrel_core_pkg::slice_t   ld_slice,
  input  barrel_core_pkg::reg_sel_t ld_sel,
  input  barrel_core_pkg::word_t    ld_data
);

  barrel_core_pkg::word_t regs [`BC_SLICES][`BC_REGS];

  // All four read ports serve the slice currently in decode
  assign au_ra    = regs[dec_slice][au_ra_sel];
  assign au_rb    = regs[dec_slice][au_rb_sel];
  assign ls_ptr   = regs[dec_slice][ls_ptr_sel];
  assign ls_store = regs[dec_slice][ls_data_sel];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int s = 0; s < `BC_SLICES; s++) begin
        for (int r = 0; r < `BC_REGS; r++) begin
          regs[s][r] <= '0;
        end
      end
    end else begin
      if (au_wr_vld) begin
        regs[au_wr_slice][au_wr_sel] <= au_wr_data;
      end
      // Load comes last, so it wins when both ports hit one register
      if (ld_vld) begin
        regs[ld_slice][ld_sel] <= ld_data;
      end
    end
  end

endmodule

//--- sim.f
+incdir+rtl
rtl/barrel_core_pkg.sv
rtl/core_fetch.sv
rtl/core_au.sv
rtl/core_ls.sv
rtl/core_regfile.sv
rtl/barrel_core.sv
sim/barrel_core_tb.sv

//--- sim/barrel_core_cases.txt
# I slice pc word | M byte_address word | E byte_address store_data (all hex)
# E lines for one address are listed in the order the stores must happen
# Slice 0 runs add and sub, pointer 0x20
I 0 00 7E400000
I 0 01 72B40000
I 0 02 74786F40
I 0 03 16508F01
I 0 04 28509F01
I 0 05 7C22A702
I 0 06 1B700000
I 0 07 8000AF03
# Slice 1 runs and and or, pointer 0x60
I 1 00 7EC00000
I 1 01 73860000
I 1 02 752C6F40
I 1 03 36508F01
I 1 04 48509F01
I 1 05 7C02A702
I 1 06 1B700000
I 1 07 8000AF03
# Slice 2 runs xor and shl, pointer 0xA0
I 2 00 7F400000
I 2 01 72E20000
I 2 02 740A6F40
I 2 03 56508F01
I 2 04 68509F01
I 2 05 7DE2A702
I 2 06 1B700000
I 2 07 8000AF03
# Slice 3 runs sub and xor, pointer 0xE0
I 3 00 7FC00000
I 3 01 72560000
I 3 02 75CE6F40
I 3 03 26508F01
I 3 04 58509F01
I 3 05 7C40A702
I 3 06 1B700000
I 3 07 8000AF03
M 120 12345678
M 160 0000FFFF
M 1A0 A5A50F0F
M 1E0 7FFFFFF0
E 24 0000005A
E 24 00000096
E 28 0000001E
E 2C 12345689
E 64 000000C3
E 64 00000082
E 68 000000D7
E 6C 00010000
E A4 00000071
E A4 00000074
E A8 00000E20
E AC A5A51000
E E4 0000002B
E E4 FFFFFF44
E E8 000000CC
E EC 80000010

//--- sim/barrel_core_tb.sv
// Barrel core testbench
`timescale 1ns/1ns
`include "barrel_core_defines.svh"

module barrel_core_tb;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int MAX_EXPECT = 64;

  logic                    CLK = 1'b0;
  logic                    reset = 1'b1;
  logic                    ics;
  barrel_core_pkg::iaddr_t iaddr;
  barrel_core_pkg::word_t  idata = '0;
  logic                    dcs;
  logic                    dwr;
  barrel_core_pkg::word_t  daddr;
  barrel_core_pkg::word_t  dout;
  barrel_core_pkg::word_t  din = '0;
  logic                    done;

  barrel_core_pkg::word_t imem [IMEM_WORDS];
  barrel_core_pkg::word_t dmem [DMEM_WORDS];
  barrel_core_pkg::word_t exp_addr [MAX_EXPECT];
  barrel_core_pkg::word_t exp_data [MAX_EXPECT];
  logic                   exp_hit [MAX_EXPECT];
  int                     exp_cnt = 0;
  int                     instr_lines = 0;
  int                     mismatches = 0;
  int                     other_errors = 0;
  int                     cycle_cnt = 0;
  int                     cycle_limit = 50;
  integer                 seed;

  // Fetch order that follows from the fixed slice rotation
  barrel_core_pkg::slice_t exp_slice = '0;
  logic                    fetch_started = 1'b0;
  logic [`BC_PC_W-1:0]     fetch_pc [`BC_SLICES];

  // Bus requests are captured mid cycle and served on the next rising edge
  logic                    ics_q = 1'b0;
  barrel_core_pkg::iaddr_t iaddr_q = '0;
  logic                    dcs_q = 1'b0;
  logic                    dwr_q = 1'b0;
  barrel_core_pkg::word_t  daddr_q = '0;
  barrel_core_pkg::word_t  dout_q = '0;

  barrel_core barrel_core_i (
    .CLK(CLK),
    .reset(reset),
    .ics(ics),
    .iaddr(iaddr),
    .idata(idata),
    .dcs(dcs),
    .dwr(dwr),
    .daddr(daddr),
    .dout(dout),
    .din(din),
    .done(done)
  );

  always #50 CLK = ~CLK;

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    fd = $fopen("sim/barrel_core_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file sim/barrel_core_cases.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        tag = 8'h00;
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
          case (tag)
            "I": begin
              imem[{f1[1:0], f2[5:0]}] = f3;
              instr_lines++;
            end
            "M": begin
              dmem[f1[9:2]] = f2;
            end
            "E": begin
              if (exp_cnt < MAX_EXPECT) begin
                exp_addr[exp_cnt] = f1;
                exp_data[exp_cnt] = f2;
                exp_hit[exp_cnt]  = 1'b0;
                exp_cnt++;
              end
            end
            default: begin
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // Matches a store against the oldest open expectation for its address
  task automatic check_store(input barrel_core_pkg::word_t addr,
                             input barrel_core_pkg::word_t data);
    int k;
    k = 0;
    while (k < exp_cnt && (exp_hit[k] || exp_addr[k] != addr)) begin
      k++;
    end
    if (k == exp_cnt) begin
      $display("Unexpected store of %h to address %h", data, addr);
      other_errors++;
    end else begin
      exp_hit[k] = 1'b1;
      if (data !== exp_data[k]) begin
        $display("Mismatch: dout at address %h is %h, expected %h", addr, data, exp_data[k]);
        mismatches++;
      end
    end
  endtask

  always @(negedge CLK) begin
    ics_q   <= ics;
    iaddr_q <= iaddr;
    dcs_q   <= dcs;
    dwr_q   <= dwr;
    daddr_q <= daddr;
    dout_q  <= dout;
    // Each fetch comes from the slice in turn at that slice's next program counter
    if (ics) begin
      if (iaddr !== {exp_slice, fetch_pc[exp_slice]}) begin
        $display("Mismatch: iaddr is %h, expected %h", iaddr, {exp_slice, fetch_pc[exp_slice]});
        mismatches++;
      end
      fetch_pc[exp_slice] = fetch_pc[exp_slice] + 1'b1;
    end
    // The rotation moves on every cycle once slice 0 has issued
    if (ics || fetch_started) begin
      fetch_started = 1'b1;
      exp_slice = exp_slice + 1'b1;
    end
    if (dcs && (daddr[31:10] != '0 || daddr[1:0] != 2'b00)) begin
      $display("Data access to address %h lies outside the data memory", daddr);
      other_errors++;
    end else if (dcs && dwr) begin
      check_store(daddr, dout);
    end
    // The core must stay silent once it reports done
    if (done && (ics || dcs)) begin
      $display("Bus activity after done: ics %b, dcs %b", ics, dcs);
      other_errors++;
    end
  end

  // Instruction and data memories answer one cycle after the strobe
  always @(posedge CLK) begin
    if (ics_q) begin
      idata <= imem[iaddr_q];
    end else begin
      idata <= '0;
    end
    if (dcs_q && !dwr_q) begin
      din <= dmem[daddr_q[9:2]];
    end
    if (dcs_q && dwr_q) begin
      dmem[daddr_q[9:2]] <= dout_q;
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: done did not rise within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    seed = 32'h7204bcac;
    for (int i = 0; i < `BC_SLICES; i++) begin
      fetch_pc[i] = '0;
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = $random(seed);
    end
    load_cases();
    cycle_limit = 16 * instr_lines + 50;

    repeat (5) @(posedge CLK);
    reset <= 1'b0;

    // One edge after release the core is still in its reset state
    @(negedge CLK);
    if (ics !== 1'b0) begin
      $display("Mismatch: ics after reset is %h, expected %h", ics, 1'b0);
      mismatches++;
    end
    if (dcs !== 1'b0) begin
      $display("Mismatch: dcs after reset is %h, expected %h", dcs, 1'b0);
      mismatches++;
    end
    if (dwr !== 1'b0) begin
      $display("Mismatch: dwr after reset is %h, expected %h", dwr, 1'b0);
      mismatches++;
    end
    if (done !== 1'b0) begin
      $display("Mismatch: done after reset is %h, expected %h", done, 1'b0);
      mismatches++;
    end

    wait (done === 1'b1);
    repeat (8) @(negedge CLK);

    for (int k = 0; k < exp_cnt; k++) begin
      if (!exp_hit[k]) begin
        $display("Expected store of %h to address %h never happened", exp_data[k], exp_addr[k]);
        other_errors++;
      end
    end

    $display("Error counts: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
